// ==== src.f ====
design/isa_pkg.sv
design/ctrl_pkg.sv
design/fetch_unit.sv
design/controller.sv
design/regfile.sv
design/alu_shifter.sv
design/datapath.sv
design/cpu_top.sv
test/tb_rom.sv
test/tb_cpu_top.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_cpu_top
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o sim_bin
	./$(BUILD_DIR)/sim_bin | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== test/tb_cpu_top.sv ====
`timescale 1ns/1ns

module tb_cpu_top;

    localparam int DATA_W     = 16;
    localparam int ADDR_W     = 8;
    localparam int PROG_LEN   = 15;
    localparam int CLK_PERIOD = 100;
    localparam int WATCHDOG   = PROG_LEN * 12 + 20;

    logic              clk;
    logic              rst_n;
    logic [15:0]       wb_dat;
    logic              wb_ack;
    logic              wb_cyc;
    logic              wb_stb;
    logic [ADDR_W-1:0] wb_adr;
    logic              commit_valid;
    logic [2:0]        commit_reg;
    logic [DATA_W-1:0] commit_data;
    logic [2:0]        status;
    logic              halted;

    logic [2:0]        exp_regs[$];
    logic [DATA_W-1:0] exp_data[$];
    logic [2:0]        exp_status [PROG_LEN];   // flags before each address executes
    logic [2:0]        final_status;
    int                exp_commits;
    int                exp_fetches;
    int                commits;
    int                fetches;
    int                value_errors;
    int                protocol_errors;
    logic [2:0]        er;
    logic [DATA_W-1:0] ed;
    logic              stb_prev;

    cpu_top #(.DATA_W(DATA_W), .ADDR_W(ADDR_W)) cpu_top_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .wb_dat       (wb_dat),
        .wb_ack       (wb_ack),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_adr       (wb_adr),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .status       (status),
        .halted       (halted)
    );

    tb_rom #(.ADDR_W(ADDR_W)) tb_rom_inst (
        .clk   (clk),
        .rst_n (rst_n),
        .cyc   (wb_cyc),
        .stb   (wb_stb),
        .adr   (wb_adr),
        .dat   (wb_dat),
        .ack   (wb_ack)
    );

    function automatic logic [DATA_W-1:0] shifted(logic [DATA_W-1:0] v, logic [1:0] sh);
        case (sh)
            2'b01:   return v << 1;
            2'b10:   return v >> 1;
            2'b11:   return $unsigned($signed(v) >>> 1);
            default: return v;
        endcase
    endfunction

    // walks the program by the isa rules with flags packed as {z, n, v}
    task automatic build_model();
        logic [DATA_W-1:0]       r [8];
        logic [DATA_W-1:0]       s;
        logic [DATA_W-1:0]       d;
        logic signed [DATA_W:0]  wide;
        logic [15:0]             ins;
        logic [2:0]              flags;
        int                      pc;
        for (int i = 0; i < 8; i++) r[i] = '0;
        flags = 3'b000;
        pc = 0;
        exp_commits = 0;
        forever begin
            ins = tb_rom_inst.mem[pc];
            if (pc < PROG_LEN) exp_status[pc] = flags;
            s = shifted(r[ins[2:0]], ins[4:3]);
            if (ins[15:13] == 3'b111) break;
            if (ins[15:13] == 3'b110 && ins[12:11] == 2'b10) begin
                r[ins[10:8]] = {{(DATA_W-8){ins[7]}}, ins[7:0]};
                exp_regs.push_back(ins[10:8]);
                exp_data.push_back(r[ins[10:8]]);
            end else if (ins[15:13] == 3'b110 && ins[12:11] == 2'b00) begin
                r[ins[7:5]] = s;
                exp_regs.push_back(ins[7:5]);
                exp_data.push_back(s);
            end else if (ins[15:13] == 3'b101 && ins[12:11] == 2'b01) begin
                wide = $signed({r[ins[10:8]][DATA_W-1], r[ins[10:8]]})
                       - $signed({s[DATA_W-1], s});
                d = wide[DATA_W-1:0];
                flags[2] = (d == '0);
                flags[1] = d[DATA_W-1];
                flags[0] = (wide[DATA_W] != wide[DATA_W-1]);   // result left the signed range
            end else if (ins[15:13] == 3'b101) begin
                case (ins[12:11])
                    2'b00:   d = r[ins[10:8]] + s;
                    2'b10:   d = r[ins[10:8]] & s;
                    default: d = ~s;
                endcase
                r[ins[7:5]] = d;
                exp_regs.push_back(ins[7:5]);
                exp_data.push_back(d);
            end
            pc++;
        end
        exp_commits = exp_regs.size();
        exp_fetches = pc + 1;
        final_status = flags;
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG * CLK_PERIOD);
        $display("timeout: the processor did not reach halt in time");
        $display("Finished with errors");
        $finish;
    end

    reset_idle: assert property (@(posedge clk)
        $rose(rst_n) |-> !wb_cyc && !wb_stb && !commit_valid && !halted)
        else begin
            $display("outputs were not idle after reset");
            protocol_errors++;
        end

    adr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else begin
            $display("bus request or address changed before ack");
            protocol_errors++;
        end

    halt_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        halted |=> halted)
        else begin
            $display("halted dropped after it was raised");
            protocol_errors++;
        end

    quiet_after_halt: assert property (@(posedge clk) disable iff (!rst_n)
        halted |-> !wb_stb && !wb_cyc && !commit_valid)
        else begin
            $display("bus request or commit while halted");
            protocol_errors++;
        end

    always @(posedge clk) begin
        if (rst_n && commit_valid) begin
            commits++;
            if (exp_regs.size() == 0) begin
                $display("a commit arrived with no write left in the model");
                protocol_errors++;
            end else begin
                er = exp_regs.pop_front();
                ed = exp_data.pop_front();
                assert (commit_reg == er) else begin
                    $display("FAIL commit_reg got %h expected %h", commit_reg, er);
                    value_errors++;
                end
                assert (commit_data == ed) else begin
                    $display("FAIL commit_data got %h expected %h", commit_data, ed);
                    value_errors++;
                end
            end
        end
    end

    // addresses count up from zero and flags are checked as each fetch opens
    always @(posedge clk) begin
        if (rst_n && wb_stb && wb_ack) begin
            assert (wb_adr == ADDR_W'(fetches)) else begin
                $display("FAIL wb_adr got %h expected %h", wb_adr, ADDR_W'(fetches));
                value_errors++;
            end
            fetches++;
        end
        if (rst_n && wb_stb && !stb_prev && wb_adr < PROG_LEN) begin
            assert (status == exp_status[wb_adr]) else begin
                $display("FAIL status got %h expected %h", status, exp_status[wb_adr]);
                value_errors++;
            end
        end
        stb_prev <= rst_n && wb_stb;
    end

    initial begin
        rst_n = 1'b0;
        commits = 0;
        fetches = 0;
        value_errors = 0;
        protocol_errors = 0;
        stb_prev = 1'b0;
        repeat (3) @(posedge clk);
        build_model();
        #1 rst_n = 1'b1;
        while (!halted) @(posedge clk);
        repeat (5) @(posedge clk);
        assert (commits == exp_commits) else begin
            $display("FAIL commit count got %h expected %h", commits, exp_commits);
            value_errors++;
        end
        assert (fetches == exp_fetches) else begin
            $display("FAIL fetch count got %h expected %h", fetches, exp_fetches);
            value_errors++;
        end
        assert (status == final_status) else begin
            $display("FAIL status got %h expected %h", status, final_status);
            value_errors++;
        end
        $display("value errors %0d, protocol errors %0d", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule : tb_cpu_top

// ==== test/tb_rom.sv ====
`timescale 1ns/1ns

module tb_rom #(
    parameter int ADDR_W = 8
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cyc,
    input  logic              stb,
    input  logic [ADDR_W-1:0] adr,
    output logic [15:0]       dat,
    output logic              ack
);

    logic [15:0] mem [2**ADDR_W];
    logic [31:0] lfsr;
    int          waits_left;

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};   // taps 32,22,2,1
    endfunction

    // two lfsr bits give 0 to 3 wait states
    task automatic pick_waits();
        logic [1:0] w;
        lfsr = lfsr_step(lfsr);
        w[0] = lfsr[0];
        lfsr = lfsr_step(lfsr);
        w[1] = lfsr[0];
        waits_left = int'(w);
    endtask

    initial begin
        for (int i = 0; i < 2**ADDR_W; i++) begin
            mem[i] = 16'he000 | 16'(i);   // halt with the address in the low bits
        end
        mem[0]  = 16'hd07f;   // mov r0, #0x7f
        mem[1]  = 16'hd180;   // mov r1, #-128
        mem[2]  = 16'hd201;   // mov r2, #1
        mem[3]  = 16'hc069;   // mov r3, r1 lsl
        mem[4]  = 16'hc091;   // mov r4, r1 lsr
        mem[5]  = 16'hc0b9;   // mov r5, r1 asr
        mem[6]  = 16'hc0c0;   // mov r6, r0
        mem[7]  = 16'ha4e4;   // add r7, r4, r4 overflows
        mem[8]  = 16'hb160;   // and r3, r1, r0
        mem[9]  = 16'hb840;   // mvn r2, r0
        mem[10] = 16'ha800;   // cmp r0, r0 equal
        mem[11] = 16'h1234;   // undefined opcode
        mem[12] = 16'ha900;   // cmp r1, r0 negative
        mem[13] = 16'hac01;   // cmp r4, r1 overflow
        mem[14] = 16'he000;   // halt
        lfsr = 32'h61f4;
        pick_waits();
        ack = 1'b0;
        dat = 16'h0000;
    end

    always @(posedge clk) begin
        if (!rst_n) begin
            ack <= #1 1'b0;
        end else if (ack) begin
            ack <= #1 1'b0;   // one ack per transfer
            pick_waits();
        end else if (cyc && stb) begin
            if (waits_left == 0) begin
                dat <= #1 mem[adr];
                ack <= #1 1'b1;
            end else begin
                waits_left--;
            end
        end
    end

endmodule : tb_rom

// ==== design/cpu_top.sv ====
`timescale 1ns/1ns

module cpu_top #(
    parameter int DATA_W = 16,
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  isa_pkg::instr_t     wb_dat,
    input  logic                wb_ack,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic [ADDR_W-1:0]   wb_adr,
    output logic                commit_valid,
    output isa_pkg::reg_idx_t   commit_reg,
    output logic [DATA_W-1:0]   commit_data,
    output ctrl_pkg::status_t   status,
    output logic                halted
);

    logic               fetch_req;
    logic               clear_pc;
    logic               fetch_done;
    isa_pkg::fields_t   fields;
    ctrl_pkg::dp_ctrl_t ctrl;

    fetch_unit #(.ADDR_W(ADDR_W)) fetch_unit_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_req  (fetch_req),
        .clear_pc   (clear_pc),
        .wb_dat     (wb_dat),
        .wb_ack     (wb_ack),
        .fetch_done (fetch_done),
        .fields     (fields),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_adr     (wb_adr)
    );

    controller controller_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .fetch_done (fetch_done),
        .fields     (fields),
        .fetch_req  (fetch_req),
        .clear_pc   (clear_pc),
        .ctrl       (ctrl),
        .halted     (halted)
    );

    datapath #(.DATA_W(DATA_W)) datapath_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .ctrl         (ctrl),
        .fields       (fields),
        .commit_valid (commit_valid),
        .commit_reg   (commit_reg),
        .commit_data  (commit_data),
        .status       (status)
    );

endmodule : cpu_top

// ==== design/datapath.sv ====
`timescale 1ns/1ns

module datapath #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  ctrl_pkg::dp_ctrl_t  ctrl,
    input  isa_pkg::fields_t    fields,
    output logic                commit_valid,
    output isa_pkg::reg_idx_t   commit_reg,
    output logic [DATA_W-1:0]   commit_data,
    output ctrl_pkg::status_t   status
);

    isa_pkg::reg_idx_t  sel_idx;
    logic [DATA_W-1:0]  r_data;
    logic [DATA_W-1:0]  imm_ext;
    logic [DATA_W-1:0]  a_q, b_q, c_q;
    logic [DATA_W-1:0]  alu_a, alu_b;
    logic [DATA_W-1:0]  alu_result;
    logic [DATA_W-1:0]  wb_data;
    ctrl_pkg::status_t  alu_status;

    // one index serves the read and the write port
    always_comb begin
        case (ctrl.reg_sel)
            ctrl_pkg::REG_RN: sel_idx = fields.rn;
            ctrl_pkg::REG_RD: sel_idx = fields.rd;
            ctrl_pkg::REG_RM: sel_idx = fields.rm;
            default:          sel_idx = fields.rm;
        endcase
    end

    assign imm_ext = {{(DATA_W-8){fields.imm8[7]}}, fields.imm8};
    assign wb_data = (ctrl.wb_sel == ctrl_pkg::WB_C) ? c_q : imm_ext;

    regfile #(.DATA_W(DATA_W)) regfile_inst (
        .clk    (clk),
        .rst_n  (rst_n),
        .w_en   (ctrl.w_en),
        .w_idx  (sel_idx),
        .w_data (wb_data),
        .r_idx  (sel_idx),
        .r_data (r_data)
    );

    always_ff @(posedge clk) begin
        if (ctrl.load_a) a_q <= r_data;
        if (ctrl.load_b) b_q <= r_data;
        if (ctrl.load_c) c_q <= alu_result;
    end

    assign alu_a = ctrl.sel_a ? '0 : a_q;
    assign alu_b = ctrl.sel_b ? imm_ext : b_q;

    alu_shifter #(.DATA_W(DATA_W)) alu_shifter_inst (
        .a      (alu_a),
        .b      (alu_b),
        .shift  (fields.shift),
        .op     (fields.op),
        .result (alu_result),
        .status (alu_status)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) status <= '0;
        else if (ctrl.load_status) status <= alu_status;   // only cmp updates flags
    end

    assign commit_valid = ctrl.w_en;
    assign commit_reg   = sel_idx;
    assign commit_data  = wb_data;

endmodule : datapath

// ==== design/alu_shifter.sv ====
`timescale 1ns/1ns

module alu_shifter #(
    parameter int DATA_W = 16
) (
    input  logic [DATA_W-1:0]   a,
    input  logic [DATA_W-1:0]   b,
    input  isa_pkg::shift_t     shift,
    input  isa_pkg::aluop_t     op,
    output logic [DATA_W-1:0]   result,
    output ctrl_pkg::status_t   status
);

    logic [DATA_W-1:0] b_sh;
    logic              ovf;

    always_comb begin
        case (shift)
            isa_pkg::SH_NONE: b_sh = b;
            isa_pkg::SH_LSL:  b_sh = {b[DATA_W-2:0], 1'b0};
            isa_pkg::SH_LSR:  b_sh = {1'b0, b[DATA_W-1:1]};
            isa_pkg::SH_ASR:  b_sh = {b[DATA_W-1], b[DATA_W-1:1]};   // keep sign
            default:          b_sh = b;
        endcase
    end

    always_comb begin
        ovf = 1'b0;
        case (op)
            isa_pkg::ALU_ADD: begin
                result = a + b_sh;
                ovf    = (a[DATA_W-1] == b_sh[DATA_W-1]) && (result[DATA_W-1] != a[DATA_W-1]);
            end
            isa_pkg::ALU_CMP: begin
                result = a - b_sh;
                ovf    = (a[DATA_W-1] != b_sh[DATA_W-1]) && (result[DATA_W-1] != a[DATA_W-1]);
            end
            isa_pkg::ALU_AND: result = a & b_sh;
            isa_pkg::ALU_MVN: result = ~b_sh;
            default:          result = '0;
        endcase
    end

    assign status.z = (result == '0);
    assign status.n = result[DATA_W-1];
    assign status.v = ovf;

endmodule : alu_shifter

// ==== design/regfile.sv ====
`timescale 1ns/1ns

module regfile #(
    parameter int DATA_W = 16
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                w_en,
    input  isa_pkg::reg_idx_t   w_idx,
    input  logic [DATA_W-1:0]   w_data,
    input  isa_pkg::reg_idx_t   r_idx,
    output logic [DATA_W-1:0]   r_data
);

    logic [DATA_W-1:0] regs [8];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (w_en) begin
            regs[w_idx] <= w_data;
        end
    end

    assign r_data = regs[r_idx];   // read is combinational

endmodule : regfile

// ==== design/controller.sv ====
`timescale 1ns/1ns

module controller (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_done,
    input  isa_pkg::fields_t    fields,
    output logic                fetch_req,
    output logic                clear_pc,
    output ctrl_pkg::dp_ctrl_t  ctrl,
    output logic                halted
);

    ctrl_pkg::state_t state;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ctrl_pkg::FETCH_RST;
        end else begin
            case (state)
                ctrl_pkg::FETCH_RST, ctrl_pkg::FETCH: begin
                    if (fetch_done) state <= ctrl_pkg::DECODE;   // wait states stall here
                end
                ctrl_pkg::DECODE: begin
                    case (fields.opcode)
                        isa_pkg::OPC_ALU: begin
                            case (fields.op)
                                isa_pkg::ALU_ADD: state <= ctrl_pkg::ADD1;
                                isa_pkg::ALU_CMP: state <= ctrl_pkg::CMP1;
                                isa_pkg::ALU_AND: state <= ctrl_pkg::AND1;
                                isa_pkg::ALU_MVN: state <= ctrl_pkg::MVN1;
                                default:          state <= ctrl_pkg::FETCH;
                            endcase
                        end
                        isa_pkg::OPC_MOV: begin
                            if (fields.op == isa_pkg::MOV_IMM)
                                state <= ctrl_pkg::MOV1;
                            else if (fields.op == isa_pkg::MOV_REG)
                                state <= ctrl_pkg::MOV_1;
                            else
                                state <= ctrl_pkg::FETCH;
                        end
                        isa_pkg::OPC_HALT: state <= ctrl_pkg::HALT;
                        default:           state <= ctrl_pkg::FETCH;   // undefined opcode is skipped
                    endcase
                end
                ctrl_pkg::MOV_1: state <= ctrl_pkg::MOV_2;
                ctrl_pkg::MOV_2: state <= ctrl_pkg::MOV_3;
                ctrl_pkg::MVN1:  state <= ctrl_pkg::MVN2;
                ctrl_pkg::MVN2:  state <= ctrl_pkg::MVN3;
                ctrl_pkg::ADD1:  state <= ctrl_pkg::ADD2;
                ctrl_pkg::ADD2:  state <= ctrl_pkg::ADD3;
                ctrl_pkg::ADD3:  state <= ctrl_pkg::ADD4;
                ctrl_pkg::CMP1:  state <= ctrl_pkg::CMP2;
                ctrl_pkg::CMP2:  state <= ctrl_pkg::CMP3;
                ctrl_pkg::AND1:  state <= ctrl_pkg::AND2;
                ctrl_pkg::AND2:  state <= ctrl_pkg::AND3;
                ctrl_pkg::AND3:  state <= ctrl_pkg::AND4;
                ctrl_pkg::HALT:  state <= ctrl_pkg::HALT;
                default:         state <= ctrl_pkg::FETCH;   // last step of every sequence
            endcase
        end
    end

    always_comb begin
        ctrl      = '0;
        fetch_req = 1'b0;
        clear_pc  = 1'b0;
        case (state)
            ctrl_pkg::FETCH_RST: begin
                fetch_req = 1'b1;
                clear_pc  = 1'b1;
            end
            ctrl_pkg::FETCH: fetch_req = 1'b1;
            ctrl_pkg::MOV1: begin
                ctrl.reg_sel = ctrl_pkg::REG_RN;   // immediate lands in rn
                ctrl.wb_sel  = ctrl_pkg::WB_IMM;
                ctrl.w_en    = 1'b1;
            end
            ctrl_pkg::ADD1, ctrl_pkg::CMP1, ctrl_pkg::AND1: begin
                ctrl.reg_sel = ctrl_pkg::REG_RN;
                ctrl.load_a  = 1'b1;
            end
            ctrl_pkg::ADD2, ctrl_pkg::CMP2, ctrl_pkg::AND2,
            ctrl_pkg::MOV_1, ctrl_pkg::MVN1: begin
                ctrl.reg_sel = ctrl_pkg::REG_RM;
                ctrl.load_b  = 1'b1;
            end
            ctrl_pkg::ADD3, ctrl_pkg::AND3: ctrl.load_c = 1'b1;
            ctrl_pkg::MOV_2, ctrl_pkg::MVN2: begin
                ctrl.sel_a  = 1'b1;   // 0 + shifted rm
                ctrl.load_c = 1'b1;
            end
            ctrl_pkg::CMP3: ctrl.load_status = 1'b1;
            ctrl_pkg::ADD4, ctrl_pkg::AND4, ctrl_pkg::MOV_3, ctrl_pkg::MVN3: begin
                ctrl.reg_sel = ctrl_pkg::REG_RD;
                ctrl.wb_sel  = ctrl_pkg::WB_C;
                ctrl.w_en    = 1'b1;
            end
            default: ;
        endcase
    end

    assign halted = (state == ctrl_pkg::HALT);

    no_write_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        !(ctrl.w_en && fetch_req))
        else $error("register write during fetch");

    // fetch unit answers only an open request
    done_needs_req: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_done |-> fetch_req)
        else $error("fetch_done without fetch_req");

endmodule : controller

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ns

module fetch_unit #(
    parameter int ADDR_W = 8
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                fetch_req,
    input  logic                clear_pc,
    input  isa_pkg::instr_t     wb_dat,
    input  logic                wb_ack,
    output logic                fetch_done,
    output isa_pkg::fields_t    fields,
    output logic                wb_cyc,
    output logic                wb_stb,
    output logic [ADDR_W-1:0]   wb_adr
);

    typedef enum logic {F_IDLE, F_REQ} fstate_t;

    fstate_t            fstate;
    logic [ADDR_W-1:0]  pc;
    isa_pkg::instr_t    ir;

    assign fetch_done = (fstate == F_REQ) && wb_ack;   // ir loads on this edge

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fstate <= F_IDLE;
            pc     <= '0;
        end else begin
            case (fstate)
                F_IDLE: if (fetch_req) fstate <= F_REQ;
                F_REQ:  if (wb_ack) fstate <= F_IDLE;
                default: fstate <= F_IDLE;
            endcase
            if (fetch_done)
                pc <= pc + 1'b1;
            else if (clear_pc && fstate == F_IDLE)
                pc <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_done) ir <= wb_dat;
    end

    assign fields = isa_pkg::to_fields(ir);
    assign wb_cyc = (fstate == F_REQ);
    assign wb_stb = (fstate == F_REQ);
    assign wb_adr = pc;

    // a waiting cycle keeps the request and its address
    stb_hold: assert property (@(posedge clk) disable iff (!rst_n)
        wb_stb && !wb_ack |=> wb_stb && $stable(wb_adr))
        else $error("stb or adr changed before ack");

endmodule : fetch_unit

// ==== design/ctrl_pkg.sv ====
package ctrl_pkg;

    typedef enum logic [4:0] {
        FETCH_RST,
        FETCH,
        DECODE,
        HALT,
        MOV1,                    // mov immediate
        MOV_1, MOV_2, MOV_3,     // mov register
        MVN1, MVN2, MVN3,
        ADD1, ADD2, ADD3, ADD4,
        CMP1, CMP2, CMP3,
        AND1, AND2, AND3, AND4
    } state_t;

    typedef logic [1:0] reg_sel_t;

    localparam reg_sel_t REG_RM = 2'b00;
    localparam reg_sel_t REG_RD = 2'b01;
    localparam reg_sel_t REG_RN = 2'b10;

    localparam logic WB_C   = 1'b0;
    localparam logic WB_IMM = 1'b1;

    typedef struct packed {
        logic     load_a;
        logic     load_b;
        logic     load_c;
        logic     load_status;
        logic     sel_a;    // zero into the alu a input
        logic     sel_b;    // immediate into the alu b input
        reg_sel_t reg_sel;
        logic     wb_sel;
        logic     w_en;
    } dp_ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_t;

endpackage : ctrl_pkg

// ==== design/isa_pkg.sv ====
package isa_pkg;

    typedef logic [15:0] instr_t;
    typedef logic [2:0]  opcode_t;
    typedef logic [1:0]  aluop_t;
    typedef logic [2:0]  reg_idx_t;
    typedef logic [1:0]  shift_t;

    localparam opcode_t OPC_ALU  = 3'b101;
    localparam opcode_t OPC_MOV  = 3'b110;
    localparam opcode_t OPC_HALT = 3'b111;

    // sub-operations under OPC_ALU
    localparam aluop_t ALU_ADD = 2'b00;
    localparam aluop_t ALU_CMP = 2'b01;
    localparam aluop_t ALU_AND = 2'b10;
    localparam aluop_t ALU_MVN = 2'b11;

    // sub-operations under OPC_MOV
    localparam aluop_t MOV_IMM = 2'b10;
    localparam aluop_t MOV_REG = 2'b00;

    localparam shift_t SH_NONE = 2'b00;
    localparam shift_t SH_LSL  = 2'b01;
    localparam shift_t SH_LSR  = 2'b10;
    localparam shift_t SH_ASR  = 2'b11;

    typedef struct packed {
        opcode_t  opcode;
        aluop_t   op;
        reg_idx_t rn;
        reg_idx_t rd;
        shift_t   shift;
        reg_idx_t rm;
        logic [7:0] imm8;
    } fields_t;

    // imm8 overlaps rd, shift and rm
    function automatic fields_t to_fields(instr_t instr);
        fields_t f;
        f.opcode = instr[15:13];
        f.op     = instr[12:11];
        f.rn     = instr[10:8];
        f.rd     = instr[7:5];
        f.shift  = instr[4:3];
        f.rm     = instr[2:0];
        f.imm8   = instr[7:0];
        return f;
    endfunction

endpackage : isa_pkg
